//--- Bender.yml
package:
  name: iir_biquad

sources:
  - src/iir_biquad_pkg.sv
  - src/arith_pkg.sv
  - src/long_divider.sv
  - src/cordic_sincos.sv
  - src/iir_coef_ctrl.sv
  - src/iir_biquad_core.sv
  - src/iir_biquad_top.sv
  - target: test
    files:
      - dv/iir_biquad_checker.sv
      - dv/iir_biquad_tb.sv

//--- dv/iir_biquad_checker.sv
`timescale 1ns/1ps

module iir_biquad_checker (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   coef_update,
  input logic                   cfg_error,
  input logic                   in_idle,
  input logic                   div_req_valid,
  input logic                   div_req_ready,
  input arith_pkg::div_req_t    div_req,
  input logic                   cordic_req_valid,
  input logic                   cordic_req_ready,
  input arith_pkg::cordic_req_t cordic_req
);

  import arith_pkg::*;

  int unsigned fail_cnt = 0;  // Assertion failures so far

  // ----------------------------------------
  // Stream rules on the request side
  // ----------------------------------------
  div_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    div_req_valid && !div_req_ready |=> div_req_valid && $stable(div_req))
    else begin
      $error("Divider request changed while stalled");
      fail_cnt++;
    end

  cordic_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cordic_req_valid && !cordic_req_ready |=> cordic_req_valid && $stable(cordic_req))
    else begin
      $error("CORDIC request changed while stalled");
      fail_cnt++;
    end

  // Update and error are exclusive outcomes
  pulse_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(coef_update && cfg_error))
    else begin
      $error("coef_update and cfg_error in the same cycle");
      fail_cnt++;
    end

  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    in_idle |-> !div_req_valid && !cordic_req_valid)
    else begin
      $error("Request valid high while controller idle");
      fail_cnt++;
    end

endmodule

bind iir_coef_ctrl iir_biquad_checker chk_i (
  .clk              (clk),
  .rst_n            (rst_n),
  .coef_update      (coef_update),
  .cfg_error        (cfg_error),
  .in_idle          (state == ST_IDLE),
  .div_req_valid    (div_req_valid),
  .div_req_ready    (div_req_ready),
  .div_req          (div_req),
  .cordic_req_valid (cordic_req_valid),
  .cordic_req_ready (cordic_req_ready),
  .cordic_req       (cordic_req)
);

//--- dv/iir_biquad_tb.sv
`timescale 1ns/1ps

module iir_biquad_tb;

  import iir_biquad_pkg::*;

  logic     clk;
  logic     rst_n;
  iir_cfg_t cfg;
  logic     x_valid;
  sample_t  x;
  logic     y_valid;
  sample_t  y;
  logic     coef_update;
  logic     cfg_error;

  int     seed = 48;
  longint cycle = 0;
  longint last_y = 0;
  longint exp_q[$];   // Expected y per sample in flight
  longint tol_q[$];
  longint cyc_q[$];   // Cycle of the x_valid
  real    rb0 = 1.0, rb1 = 0.0, rb2 = 0.0, ra1 = 0.0, ra2 = 0.0;
  real    hx1 = 0.0, hx2 = 0.0, hy1 = 0.0, hy2 = 0.0;

  iir_biquad_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function void set_ref_coefs();
    real w0, c, s, alfa;
    w0   = 2.0 * 3.14159265358979 * real'(cfg.f0) / real'(cfg.fs);
    c    = $cos(w0);
    s    = $sin(w0);
    alfa = s / (2.0 * real'(cfg.q) / 65536.0);
    case (cfg.filt_type)
      IIR_HIGH_PASS: begin
        rb0 = (1.0 + c) / 2.0;
        rb1 = -(1.0 + c);
        rb2 = rb0;
      end
      IIR_BAND_PASS: begin
        rb0 = s / 2.0;
        rb1 = 0.0;
        rb2 = -s / 2.0;
      end
      default: begin
        rb0 = (1.0 - c) / 2.0;
        rb1 = 1.0 - c;
        rb2 = rb0;
      end
    endcase
    ra1 = -2.0 * c;
    ra2 = 1.0 - alfa;    // a0 taken as one
  endfunction

  // Expected y in LSB with the history running on in bypass
  function real ref_filter(input real xin, input logic byp);
    real acc;
    acc = rb0 * xin + rb1 * hx1 + rb2 * hx2 - ra1 * hy1 - ra2 * hy2;
    if (acc > 32767.99998) acc = 32767.99998;
    if (acc < -32768.0) acc = -32768.0;
    hx2 = hx1;
    hx1 = xin;
    hy2 = hy1;
    hy1 = acc;
    return (byp ? xin : acc) * 65536.0;
  endfunction

  function real dc_gain();
    return (rb0 + rb1 + rb2) / (1.0 + ra1 + ra2);
  endfunction

  function sample_t rand_sample();
    return sample_t'($random(seed) % 16384);  // Within +-0.25
  endfunction

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(input string name, input longint got, input longint exp,
                       input longint tol);
    longint diff;
    diff = got - exp;
    if (diff < 0) diff = -diff;
    if (diff > tol) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got[31:0], exp[31:0]);
      abort_run();
    end
  endtask

  always @(negedge clk) begin
    if (dut_i.ctrl_i.chk_i.fail_cnt != 0) begin
      $display("A bound protocol assertion on the controller failed");
      abort_run();
    end
    if (rst_n && y_valid) begin
      if (exp_q.size() == 0) begin
        $display("Output valid with no sample in flight");
        abort_run();
      end
      check("y", y, exp_q.pop_front(), tol_q.pop_front());
      check("y latency", cycle - cyc_q.pop_front(), 2, 0);
      last_y = y;
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic send_sample(input sample_t val, input longint tol);
    @(posedge clk);
    #2;
    x_valid = 1'b1;
    x       = val;
    exp_q.push_back(longint'(ref_filter(real'(val) / 65536.0, cfg.bypass)));
    tol_q.push_back(tol);
    cyc_q.push_back(cycle);
    @(posedge clk);
    #2;
    x_valid = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      n++;
      if (n >= 100) begin
        $display("Timeout: outputs missing for samples already sent");
        abort_run();
      end
    end
  endtask

  // Waits for one result pulse while the other one fails the run
  task automatic wait_result(input logic want_update);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (want_update ? cfg_error : coef_update) begin
        $display("Controller gave the wrong outcome for a configuration change");
        abort_run();
      end
      done = want_update ? coef_update : cfg_error;
      n++;
      if (!done && n >= 5000) begin
        $display("Timeout: controller gave no result within 5000 cycles");
        abort_run();
      end
    end
  endtask

  task automatic settle_check(input longint exp, input longint tol);
    repeat (200) send_sample(16384, 64);
    wait_drain();
    check("y settled", last_y, exp, tol);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    longint dc;
    cfg = '{f0: 32'd500, fs: 32'd6000, q: 32'd46334, filt_type: IIR_LOW_PASS, bypass: 1'b0};
    x_valid = 1'b0;
    x       = '0;
    rst_n   = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    repeat (10) send_sample(rand_sample(), 0);  // Identity set
    wait_drain();

    #2 cfg.f0 = 32'd1000;                        // Low-pass with q = 0.707
    wait_result(1'b1);
    set_ref_coefs();
    dc = longint'(dc_gain() * 16384.0);
    settle_check(dc, (dc < 0 ? -dc : dc) / 100);
    repeat (40) send_sample(rand_sample(), 64);

    wait_drain();
    #2 cfg.filt_type = IIR_HIGH_PASS;
    wait_result(1'b1);
    set_ref_coefs();
    settle_check(0, 64);

    #2 cfg.filt_type = IIR_BAND_PASS;
    wait_result(1'b1);
    set_ref_coefs();
    settle_check(0, 64);

    #2 cfg.q = 32'd65536;                        // q alone to 1.0
    wait_result(1'b1);
    set_ref_coefs();
    repeat (40) send_sample(rand_sample(), 64);
    wait_drain();

    #2 cfg.bypass = 1'b1;
    repeat (20) send_sample(rand_sample(), 0);
    wait_drain();
    #2 cfg.bypass = 1'b0;
    repeat (20) send_sample(rand_sample(), 64);
    wait_drain();

    #2 cfg.fs = 32'd0;                           // Reference keeps old set
    wait_result(1'b0);
    repeat (40) send_sample(rand_sample(), 64);
    wait_drain();

    @(negedge clk);
    if (dut_i.ctrl_i.chk_i.fail_cnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("A bound protocol assertion on the controller failed");
      abort_run();
    end
  end

endmodule

//--- src/arith_pkg.sv
package arith_pkg;

  typedef logic signed [31:0] fix_t;    // Q15.16 operand
  typedef logic signed [31:0] angle_t;  // Radians in Q15.16

  // ----------------------------------------
  // CORDIC constants
  // ----------------------------------------

  localparam int CORDIC_ITERS = 16;

  localparam angle_t PI      = 32'sd205887;
  localparam angle_t HALF_PI = 32'sd102944;
  localparam angle_t TWO_PI  = 32'sd411775;

  localparam fix_t CORDIC_GAIN_INV = 32'sd39797;  // Start vector length of 0.60725

  // atan(2^-i)
  localparam angle_t ATAN_TABLE [CORDIC_ITERS] = '{
    32'sd51472, 32'sd30386, 32'sd16055, 32'sd8150,
    32'sd4091,  32'sd2047,  32'sd1024,  32'sd512,
    32'sd256,   32'sd128,   32'sd64,    32'sd32,
    32'sd16,    32'sd8,     32'sd4,     32'sd2
  };

  // ----------------------------------------
  // Stream payloads
  // ----------------------------------------

  typedef struct packed { fix_t data;     logic last;     } div_req_t;
  typedef struct packed { fix_t quotient; logic overflow; } div_rsp_t;
  typedef struct packed { angle_t angle;                  } cordic_req_t;
  typedef struct packed { fix_t data;     logic last;     } cordic_rsp_t;

endpackage

//--- src/cordic_sincos.sv
`timescale 1ns/1ps

module cordic_sincos (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  arith_pkg::cordic_req_t req,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output arith_pkg::cordic_rsp_t rsp
);

  import arith_pkg::*;

  typedef enum logic [2:0] {
    COR_IDLE,
    COR_FOLD,   // Map angle into 0..pi/2
    COR_ROT,
    COR_FIX,    // Apply cosine sign
    COR_SIN,
    COR_COS
  } cor_state_e;

  cor_state_e state;
  logic [3:0] iter;
  fix_t       x;
  fix_t       y;
  angle_t     z;
  angle_t     atan_i;
  logic       neg_cos;

  assign atan_i = ATAN_TABLE[iter];

  assign req_ready = (state == COR_IDLE);
  assign rsp_valid = (state == COR_SIN) || (state == COR_COS);
  assign rsp.data  = (state == COR_SIN) ? y : x;
  assign rsp.last  = (state == COR_COS);

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= COR_IDLE;
      iter  <= '0;
    end else begin
      case (state)
        COR_IDLE: if (req_valid) state <= COR_FOLD;
        COR_FOLD: begin
          iter  <= '0;
          state <= COR_ROT;
        end
        COR_ROT: begin
          iter <= iter + 4'd1;
          if (iter == 4'(CORDIC_ITERS - 1)) state <= COR_FIX;
        end
        COR_FIX: state <= COR_SIN;
        COR_SIN: if (rsp_ready) state <= COR_COS;   // Cosine follows sine
        COR_COS: if (rsp_ready) state <= COR_IDLE;
        default: state <= COR_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Rotation datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    case (state)
      COR_IDLE: if (req_valid) z <= req.angle;
      COR_FOLD: begin
        neg_cos <= (z > HALF_PI);
        if (z > HALF_PI) z <= PI - z;  // sin(pi-a) = sin(a), cos flips
        x <= CORDIC_GAIN_INV;
        y <= '0;
      end
      COR_ROT: begin
        if (!z[31]) begin
          x <= x - (y >>> iter);
          y <= y + (x >>> iter);
          z <= z - atan_i;
        end else begin
          x <= x + (y >>> iter);
          y <= y - (x >>> iter);
          z <= z + atan_i;
        end
      end
      COR_FIX: if (neg_cos) x <= -x;
      default: ;
    endcase
  end

endmodule

//--- src/iir_biquad_core.sv
`timescale 1ns/1ps

module iir_biquad_core (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       x_valid,
  input  iir_biquad_pkg::sample_t    x,
  input  logic                       bypass,
  input  iir_biquad_pkg::iir_coefs_t coefs,
  output logic                       y_valid,
  output iir_biquad_pkg::sample_t    y
);

  import iir_biquad_pkg::*;

  logic               s1_valid;
  sample_t            x_d;                   // Input kept for bypass
  sample_t            x1, x2, y1, y2;        // Filter history
  logic signed [63:0] p_b0, p_b1, p_b2, p_a1, p_a2;
  logic signed [66:0] acc;
  logic signed [66:0] acc_sh;
  sample_t            y_sat;

  // ----------------------------------------
  // Stage two sum and saturation
  // ----------------------------------------
  assign acc    = p_b0 + p_b1 + p_b2 - p_a1 - p_a2;
  assign acc_sh = acc >>> Q_BITS;

  always_comb begin
    if (acc_sh[66:31] == '0 || acc_sh[66:31] == '1) y_sat = acc_sh[31:0];
    else y_sat = acc_sh[66] ? 32'sh8000_0000 : 32'sh7fff_ffff;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      y_valid  <= 1'b0;
      {x1, x2, y1, y2} <= '0;
    end else begin
      s1_valid <= x_valid;
      y_valid  <= s1_valid;
      if (x_valid) begin
        x1 <= x;
        x2 <= x1;
      end
      if (s1_valid) begin
        y1 <= y_sat;   // Filter keeps running in bypass
        y2 <= y1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (x_valid) begin
      x_d  <= x;
      p_b0 <= coefs.b0 * x;
      p_b1 <= coefs.b1 * x1;
      p_b2 <= coefs.b2 * x2;
      p_a1 <= coefs.a1 * y1;
      p_a2 <= coefs.a2 * y2;
    end
    if (s1_valid) y <= bypass ? x_d : y_sat;
  end

endmodule

//--- src/iir_biquad_pkg.sv
package iir_biquad_pkg;

  // ----------------------------------------
  // Number format
  // ----------------------------------------

  localparam int Q_BITS = 16;  // Fraction bits of Q15.16

  typedef logic signed [31:0] sample_t;
  typedef logic signed [31:0] coef_t;
  typedef logic        [31:0] cfg_word_t;  // Hz as integer, or Q15.16 for q

  localparam coef_t ONE = coef_t'(1 << Q_BITS);  // 1.0

  // ----------------------------------------
  // Configuration and coefficients
  // ----------------------------------------

  typedef enum logic [1:0] {
    IIR_LOW_PASS  = 2'd0,
    IIR_HIGH_PASS = 2'd1,
    IIR_BAND_PASS = 2'd2
  } iir_type_e;

  typedef struct packed {
    cfg_word_t f0;         // Cut-off frequency
    cfg_word_t fs;         // Sample rate
    cfg_word_t q;          // Quality factor in Q15.16
    iir_type_e filt_type;
    logic      bypass;     // Output follows input
  } iir_cfg_t;

  // Zeros b0..b2 and poles a1..a2, a0 fixed at one
  typedef struct packed {
    coef_t b0;
    coef_t b1;
    coef_t b2;
    coef_t a1;
    coef_t a2;
  } iir_coefs_t;

endpackage

//--- src/iir_biquad_top.sv
`timescale 1ns/1ps

module iir_biquad_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  iir_biquad_pkg::iir_cfg_t cfg,
  input  logic                     x_valid,
  input  iir_biquad_pkg::sample_t  x,
  output logic                     y_valid,
  output iir_biquad_pkg::sample_t  y,
  output logic                     coef_update,
  output logic                     cfg_error
);

  import arith_pkg::*;

  iir_biquad_pkg::iir_coefs_t coefs;

  // Divider streams
  logic        div_req_valid, div_req_ready;
  div_req_t    div_req;
  logic        div_rsp_valid, div_rsp_ready;
  div_rsp_t    div_rsp;

  // CORDIC streams
  logic        cordic_req_valid, cordic_req_ready;
  cordic_req_t cordic_req;
  logic        cordic_rsp_valid, cordic_rsp_ready;
  cordic_rsp_t cordic_rsp;

  iir_coef_ctrl ctrl_i (.*);

  long_divider div_i (
    .clk       (clk),           .rst_n     (rst_n),
    .req_valid (div_req_valid), .req_ready (div_req_ready), .req (div_req),
    .rsp_valid (div_rsp_valid), .rsp_ready (div_rsp_ready), .rsp (div_rsp)
  );

  cordic_sincos cordic_i (
    .clk       (clk),              .rst_n     (rst_n),
    .req_valid (cordic_req_valid), .req_ready (cordic_req_ready), .req (cordic_req),
    .rsp_valid (cordic_rsp_valid), .rsp_ready (cordic_rsp_ready), .rsp (cordic_rsp)
  );

  iir_biquad_core core_i (
    .clk     (clk),     .rst_n (rst_n),
    .x_valid (x_valid), .x     (x),
    .bypass  (cfg.bypass),  // Level goes straight to the core
    .coefs   (coefs),
    .y_valid (y_valid), .y     (y)
  );

endmodule

//--- src/iir_coef_ctrl.sv
`timescale 1ns/1ps

module iir_coef_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  iir_biquad_pkg::iir_cfg_t   cfg,
  output iir_biquad_pkg::iir_coefs_t coefs,
  output logic                       coef_update,
  output logic                       cfg_error,
  output logic                       div_req_valid,
  input  logic                       div_req_ready,
  output arith_pkg::div_req_t        div_req,
  input  logic                       div_rsp_valid,
  output logic                       div_rsp_ready,
  input  arith_pkg::div_rsp_t        div_rsp,
  output logic                       cordic_req_valid,
  input  logic                       cordic_req_ready,
  output arith_pkg::cordic_req_t     cordic_req,
  input  logic                       cordic_rsp_valid,
  output logic                       cordic_rsp_ready,
  input  arith_pkg::cordic_rsp_t     cordic_rsp
);

  import iir_biquad_pkg::*;
  import arith_pkg::*;

  typedef enum logic [3:0] {
    ST_INIT, ST_SEND_DIV, ST_WAIT_QUO, ST_SEND_W0, ST_GET_SINCOS,
    ST_SEND_ALFA, ST_WAIT_ALFA, ST_COMPUTE, ST_IDLE
  } ctrl_state_e;

  ctrl_state_e        state;
  iir_cfg_t           cfg_q;     // Config behind the active coefficients
  iir_cfg_t           cfg_new;   // Config being worked on
  angle_t             w0;
  fix_t               sin_w0;
  fix_t               cos_w0;
  fix_t               alfa;
  fix_t               op_a;
  fix_t               op_b;
  logic signed [63:0] w0_prod;
  coef_t              one_m_c;
  coef_t              one_p_c;

  assign div_rsp_ready    = (state == ST_WAIT_QUO) || (state == ST_WAIT_ALFA);
  assign cordic_rsp_ready = (state == ST_GET_SINCOS);

  // Operands of the divisions f0/fs and sin/(2q)
  assign op_a = (state == ST_SEND_ALFA) ? sin_w0 : fix_t'(cfg_new.f0);
  assign op_b = (state == ST_SEND_ALFA) ? fix_t'(cfg_new.q << 1) : fix_t'(cfg_new.fs);

  assign w0_prod = div_rsp.quotient * TWO_PI;
  assign one_m_c = ONE - cos_w0;
  assign one_p_c = ONE + cos_w0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state            <= ST_INIT;
      cfg_q            <= '0;
      cfg_new          <= '0;
      {w0, sin_w0, cos_w0, alfa} <= '0;
      coefs            <= '{b0: ONE, default: '0};  // Identity
      coef_update      <= 1'b0;
      cfg_error        <= 1'b0;
      div_req_valid    <= 1'b0;
      div_req          <= '0;
      cordic_req_valid <= 1'b0;
      cordic_req       <= '0;
    end else begin
      coef_update <= 1'b0;
      cfg_error   <= 1'b0;
      case (state)
        ST_INIT: begin
          cfg_q <= cfg;
          state <= ST_IDLE;
        end
        ST_IDLE: begin
          cfg_new <= cfg;
          if (cfg.f0 != cfg_q.f0 || cfg.fs != cfg_q.fs) state <= ST_SEND_DIV;
          else if (cfg.q != cfg_q.q)                   state <= ST_SEND_ALFA;
          else if (cfg.filt_type != cfg_q.filt_type)   state <= ST_COMPUTE;
        end
        // Dividend beat, then divisor beat with last
        ST_SEND_DIV, ST_SEND_ALFA: begin
          if (!div_req_valid) begin
            div_req_valid <= 1'b1;
            div_req       <= '{data: op_a, last: 1'b0};
          end else if (div_req_ready) begin
            if (!div_req.last) begin
              div_req <= '{data: op_b, last: 1'b1};
            end else begin
              div_req_valid <= 1'b0;
              state <= (state == ST_SEND_DIV) ? ST_WAIT_QUO : ST_WAIT_ALFA;
            end
          end
        end
        ST_WAIT_QUO, ST_WAIT_ALFA: if (div_rsp_valid) begin
          if (div_rsp.overflow) begin
            cfg_error <= 1'b1;       // Old coefficients stay
            cfg_q     <= cfg_new;
            state     <= ST_IDLE;
          end else if (state == ST_WAIT_QUO) begin
            w0    <= w0_prod[31+Q_BITS:Q_BITS];
            state <= ST_SEND_W0;
          end else begin
            alfa  <= div_rsp.quotient;
            state <= ST_COMPUTE;
          end
        end
        ST_SEND_W0: begin
          if (!cordic_req_valid) begin
            cordic_req_valid <= 1'b1;
            cordic_req.angle <= w0;
          end else if (cordic_req_ready) begin
            cordic_req_valid <= 1'b0;
            state            <= ST_GET_SINCOS;
          end
        end
        ST_GET_SINCOS: if (cordic_rsp_valid) begin
          if (!cordic_rsp.last) begin
            sin_w0 <= cordic_rsp.data;
          end else begin
            cos_w0 <= cordic_rsp.data;
            state  <= ST_SEND_ALFA;
          end
        end
        ST_COMPUTE: begin
          case (cfg_new.filt_type)
            IIR_HIGH_PASS: begin
              coefs.b0 <= one_p_c >>> 1;
              coefs.b1 <= -one_p_c;
              coefs.b2 <= one_p_c >>> 1;
            end
            IIR_BAND_PASS: begin
              coefs.b0 <= sin_w0 >>> 1;
              coefs.b1 <= '0;
              coefs.b2 <= -(sin_w0 >>> 1);
            end
            default: begin           // Low-pass
              coefs.b0 <= one_m_c >>> 1;
              coefs.b1 <= one_m_c;
              coefs.b2 <= one_m_c >>> 1;
            end
          endcase
          coefs.a1    <= -(cos_w0 <<< 1);
          coefs.a2    <= ONE - alfa;  // Poles not scaled by a0
          coef_update <= 1'b1;
          cfg_q       <= cfg_new;
          state       <= ST_IDLE;
        end
        default: state <= ST_INIT;
      endcase
    end
  end

endmodule

//--- src/long_divider.sv
`timescale 1ns/1ps

module long_divider (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  output logic                req_ready,
  input  arith_pkg::div_req_t req,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output arith_pkg::div_rsp_t rsp
);

  import arith_pkg::*;
  import iir_biquad_pkg::*;

  typedef enum logic [1:0] {DIV_IDLE, DIV_LOAD, DIV_RUN, DIV_DONE} div_state_e;

  div_state_e         state;
  logic [5:0]         step;
  fix_t               dividend;
  fix_t               divisor;
  logic [31:0]        dvd_mag;
  logic [31:0]        dvs_mag;
  logic [31+Q_BITS:0] quo;        // Numerator shifts out, quotient shifts in
  logic [32:0]        rem;
  logic [32:0]        rem_shift;
  logic               neg;
  logic               div_zero;
  logic               too_big;

  assign req_ready = (state == DIV_IDLE);
  assign rsp_valid = (state == DIV_DONE);

  assign dvd_mag   = dividend[31] ? -dividend : dividend;
  assign rem_shift = {rem[31:0], quo[31+Q_BITS]};

  // Negative results may reach -2^31
  assign too_big = neg ? (quo > {1'b0, 32'h8000_0000}) : (quo > {1'b0, 32'h7fff_ffff});

  assign rsp.quotient = neg ? -fix_t'(quo[31:0]) : fix_t'(quo[31:0]);
  assign rsp.overflow = div_zero | too_big;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DIV_IDLE;
      step  <= '0;
    end else begin
      case (state)
        DIV_IDLE: if (req_valid && req.last) state <= DIV_LOAD;  // Divisor beat
        DIV_LOAD: begin
          step  <= '0;
          state <= DIV_RUN;
        end
        DIV_RUN: begin
          step <= step + 6'd1;
          if (step == 6'(31 + Q_BITS)) state <= DIV_DONE;
        end
        DIV_DONE: if (rsp_ready) state <= DIV_IDLE;
        default:  state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      DIV_IDLE: if (req_valid) begin
        if (req.last) divisor <= req.data;
        else          dividend <= req.data;
      end
      DIV_LOAD: begin
        quo      <= {dvd_mag, {Q_BITS{1'b0}}};
        rem      <= '0;
        dvs_mag  <= divisor[31] ? -divisor : divisor;
        neg      <= dividend[31] ^ divisor[31];
        div_zero <= (divisor == '0);
      end
      DIV_RUN: begin
        // Restoring step, one quotient bit per cycle
        if (rem_shift >= {1'b0, dvs_mag}) begin
          rem <= rem_shift - {1'b0, dvs_mag};
          quo <= {quo[30+Q_BITS:0], 1'b1};
        end else begin
          rem <= rem_shift;
          quo <= {quo[30+Q_BITS:0], 1'b0};
        end
      end
      default: ;
    endcase
  end

endmodule

//--- verilog.f
src/iir_biquad_pkg.sv
src/arith_pkg.sv
src/long_divider.sv
src/cordic_sincos.sv
src/iir_coef_ctrl.sv
src/iir_biquad_core.sv
src/iir_biquad_top.sv
dv/iir_biquad_checker.sv
dv/iir_biquad_tb.sv
